// File: pokerPkg.sv
`default_nettype none

package pokerPkg;

	// hand geometry
	localparam int NumCards = 5;
	localparam int SuitWidth = 2;
	localparam int RankWidth = 4;
	localparam int CardWidth = SuitWidth + RankWidth;
	localparam int CategoryWidth = 4;

	// field types, suit sits above rank inside a card
	typedef logic [SuitWidth-1:0] suitT;
	typedef logic [RankWidth-1:0] rankT;
	typedef logic [CardWidth-1:0] cardT;
	// card 0 in the lowest bits
	typedef logic [NumCards*CardWidth-1:0] handT;
	typedef logic [CategoryWidth-1:0] categoryT;

	// rank values with a special role
	localparam rankT AceRank = 4'd1;
	localparam rankT KingRank = 4'd13;
	// lowest rank of 10-J-Q-K-A
	localparam rankT AceHighRank = 4'd10;

	// category codes, higher value beats lower
	localparam categoryT CatHighCard = 4'd0;
	localparam categoryT CatOnePair = 4'd1;
	localparam categoryT CatTwoPairs = 4'd2;
	localparam categoryT CatThreeKind = 4'd3;
	localparam categoryT CatStraight = 4'd4;
	localparam categoryT CatFlush = 4'd5;
	localparam categoryT CatFullHouse = 4'd6;
	localparam categoryT CatFourKind = 4'd7;
	localparam categoryT CatStraightFlush = 4'd8;

endpackage

`default_nettype wire

// File: laneIf.sv
`default_nettype none

interface laneIf;
	import pokerPkg::*;

	// single-cycle strobe, hand is valid with it
	logic handValid;
	handT hand;
	// comes back exactly two cycles after handValid
	logic resultValid;
	categoryT category;

	modport dispatcher (output handValid, output hand);
	modport lane (input handValid, input hand, output resultValid, output category);
	modport collector (input resultValid, input category);

endinterface

`default_nettype wire

// File: handDispatcher.sv
`default_nettype none

module handDispatcher #(
	parameter int NumLanes = 3,
	parameter int InDepth = 4,
	parameter int ResultDepth = 4
) (
	input  logic clk,
	input  logic reset,
	input  logic inValid,
	input  pokerPkg::handT inHand,
	output logic inCredit,
	input  logic resultCredit,
	laneIf.dispatcher lanes [NumLanes]
);
	import pokerPkg::*;

	localparam int PtrWidth = (InDepth > 1) ? $clog2(InDepth) : 1;
	localparam int CountWidth = $clog2(InDepth + 1);
	localparam int CreditWidth = $clog2(ResultDepth + 1);
	localparam int LaneWidth = (NumLanes > 1) ? $clog2(NumLanes) : 1;

	// input fifo storage
	handT handBuf [InDepth];
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [CountWidth-1:0] count;
	// free slots in the collector's result buffer
	logic [CreditWidth-1:0] slotCredits;
	// lane that gets the next hand
	logic [LaneWidth-1:0] lanePtr;
	logic [NumLanes-1:0] issueValid;
	handT issueHand;
	logic issue;

	// a hand leaves only when it already owns a result slot
	assign issue = (count != '0) && (slotCredits != '0);

	// payload path
	always_ff @(posedge clk) begin
		if (inValid) begin
			handBuf[wrPtr] <= inHand;
		end
		if (issue) begin
			issueHand <= handBuf[rdPtr];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			slotCredits <= CreditWidth'(ResultDepth);
			lanePtr <= '0;
			issueValid <= '0;
			inCredit <= 1'b0;
		end else begin
			// one credit back upstream per popped hand
			inCredit <= issue;
			issueValid <= '0;
			if (inValid) begin
				if (wrPtr == PtrWidth'(InDepth - 1)) begin
					wrPtr <= '0;
				end else begin
					wrPtr <= wrPtr + PtrWidth'(1);
				end
			end
			if (issue) begin
				if (rdPtr == PtrWidth'(InDepth - 1)) begin
					rdPtr <= '0;
				end else begin
					rdPtr <= rdPtr + PtrWidth'(1);
				end
				// round robin from lane 0
				if (lanePtr == LaneWidth'(NumLanes - 1)) begin
					lanePtr <= '0;
				end else begin
					lanePtr <= lanePtr + LaneWidth'(1);
				end
				issueValid[lanePtr] <= 1'b1;
			end
			count <= count + CountWidth'(inValid) - CountWidth'(issue);
			slotCredits <= slotCredits - CreditWidth'(issue) + CreditWidth'(resultCredit);
		end
	end

	// every lane sees the same hand, only its strobe differs
	for (genvar i = 0; i < NumLanes; i++) begin : laneDrive
		assign lanes[i].handValid = issueValid[i];
		assign lanes[i].hand = issueHand;
	end

	// upstream must hold a credit, so the fifo has room
	inputNoOverflow: assert property (@(posedge clk) disable iff (reset)
		inValid |-> (count < CountWidth'(InDepth)));

	// collector never returns more slots than exist
	slotCreditBound: assert property (@(posedge clk) disable iff (reset)
		slotCredits <= CreditWidth'(ResultDepth));

endmodule

`default_nettype wire

// File: rankGroupCounter.sv
`default_nettype none

module rankGroupCounter (
	input  pokerPkg::rankT ranks [pokerPkg::NumCards],
	output logic onePair,
	output logic twoPairs,
	output logic threeKind,
	output logic fullHouse,
	output logic fourKind
);
	import pokerPkg::*;

	localparam int MatchWidth = $clog2(NumCards + 1);

	// sameRank[i][j] set when cards i and j share a rank
	logic [NumCards-1:0] sameRank [NumCards];
	// how many other cards match card i
	logic [MatchWidth-1:0] matchCount [NumCards];
	// cards that belong to any group
	logic [MatchWidth-1:0] pairedCards;
	logic exactPair;
	logic exactTrip;

	// ten pairwise compares, mirrored into the full matrix
	always_comb begin
		for (int i = 0; i < NumCards; i++) begin
			sameRank[i] = '0;
		end
		for (int i = 0; i < NumCards; i++) begin
			for (int j = i + 1; j < NumCards; j++) begin
				sameRank[i][j] = (ranks[i] == ranks[j]);
				sameRank[j][i] = (ranks[i] == ranks[j]);
			end
		end
	end

	always_comb begin
		pairedCards = '0;
		onePair = 1'b0;
		threeKind = 1'b0;
		fourKind = 1'b0;
		exactPair = 1'b0;
		exactTrip = 1'b0;
		for (int i = 0; i < NumCards; i++) begin
			matchCount[i] = MatchWidth'($countones(sameRank[i]));
			if (matchCount[i] != '0) begin
				pairedCards = pairedCards + MatchWidth'(1);
				onePair = 1'b1;
			end
			// a card in a trip matches two others, in quads three
			if (matchCount[i] >= MatchWidth'(2)) begin
				threeKind = 1'b1;
			end
			if (matchCount[i] >= MatchWidth'(3)) begin
				fourKind = 1'b1;
			end
			if (matchCount[i] == MatchWidth'(1)) begin
				exactPair = 1'b1;
			end
			if (matchCount[i] == MatchWidth'(2)) begin
				exactTrip = 1'b1;
			end
		end
		// four grouped cards means two pairs, quads and full house included
		twoPairs = (pairedCards >= MatchWidth'(4));
		fullHouse = exactTrip && exactPair;
	end

endmodule

`default_nettype wire

// File: handClassifier.sv
`default_nettype none

module handClassifier (
	input logic clk,
	input logic reset,
	laneIf.lane lane
);
	import pokerPkg::*;

	// card fields of the incoming hand
	cardT cards [NumCards];
	rankT ranks [NumCards];
	suitT suits [NumCards];

	// stage one inputs
	logic onePair;
	logic twoPairs;
	logic threeKind;
	logic fullHouse;
	logic fourKind;
	logic flush;
	logic straight;
	rankT minRank;
	rankT maxRank;
	logic aceHigh;

	// stage one registers
	logic s1Valid;
	logic s1OnePair;
	logic s1TwoPairs;
	logic s1ThreeKind;
	logic s1FullHouse;
	logic s1FourKind;
	logic s1Flush;
	logic s1Straight;

	// stage two registers
	logic s2Valid;
	categoryT s2Category;

	for (genvar i = 0; i < NumCards; i++) begin : cardSplit
		assign cards[i] = lane.hand[i*CardWidth +: CardWidth];
		assign ranks[i] = cards[i][RankWidth-1:0];
		assign suits[i] = cards[i][CardWidth-1 -: SuitWidth];
	end

	rankGroupCounter groups (
		.ranks(ranks),
		.onePair(onePair),
		.twoPairs(twoPairs),
		.threeKind(threeKind),
		.fullHouse(fullHouse),
		.fourKind(fourKind)
	);

	always_comb begin
		flush = 1'b1;
		minRank = ranks[0];
		maxRank = ranks[0];
		aceHigh = 1'b1;
		for (int i = 0; i < NumCards; i++) begin
			if (suits[i] != suits[0]) begin
				flush = 1'b0;
			end
			if (ranks[i] < minRank) begin
				minRank = ranks[i];
			end
			if (ranks[i] > maxRank) begin
				maxRank = ranks[i];
			end
			// only ace or ten..king fits 10-J-Q-K-A
			if (ranks[i] != AceRank && (ranks[i] < AceHighRank || ranks[i] > KingRank)) begin
				aceHigh = 1'b0;
			end
		end
		// distinct ranks spanning exactly four, so Q-K-A-2-3 fails
		straight = !onePair && (((maxRank - minRank) == rankT'(NumCards - 1)) || aceHigh);
	end

	always_ff @(posedge clk) begin
		s1OnePair <= onePair;
		s1TwoPairs <= twoPairs;
		s1ThreeKind <= threeKind;
		s1FullHouse <= fullHouse;
		s1FourKind <= fourKind;
		s1Flush <= flush;
		s1Straight <= straight;
		// strongest category wins
		if (s1Straight && s1Flush) begin
			s2Category <= CatStraightFlush;
		end else if (s1FourKind) begin
			s2Category <= CatFourKind;
		end else if (s1FullHouse) begin
			s2Category <= CatFullHouse;
		end else if (s1Flush) begin
			s2Category <= CatFlush;
		end else if (s1Straight) begin
			s2Category <= CatStraight;
		end else if (s1ThreeKind) begin
			s2Category <= CatThreeKind;
		end else if (s1TwoPairs) begin
			s2Category <= CatTwoPairs;
		end else if (s1OnePair) begin
			s2Category <= CatOnePair;
		end else begin
			s2Category <= CatHighCard;
		end
	end

	// valid bit rides along with the data
	always_ff @(posedge clk) begin
		if (reset) begin
			s1Valid <= 1'b0;
			s2Valid <= 1'b0;
		end else begin
			s1Valid <= lane.handValid;
			s2Valid <= s1Valid;
		end
	end

	assign lane.resultValid = s2Valid;
	assign lane.category = s2Category;

endmodule

`default_nettype wire

// File: resultCollector.sv
`default_nettype none

module resultCollector #(
	parameter int NumLanes = 3,
	parameter int ResultDepth = 4,
	parameter int SinkDepth = 2
) (
	input  logic clk,
	input  logic reset,
	laneIf.collector lanes [NumLanes],
	output logic resultCredit,
	output logic outValid,
	output pokerPkg::categoryT outCategory,
	input  logic outCredit
);
	import pokerPkg::*;

	localparam int PtrWidth = (ResultDepth > 1) ? $clog2(ResultDepth) : 1;
	localparam int CountWidth = $clog2(ResultDepth + 1);
	localparam int SinkWidth = $clog2(SinkDepth + 1);
	localparam int LaneWidth = (NumLanes > 1) ? $clog2(NumLanes) : 1;

	// lane outputs gathered into arrays for indexing
	logic [NumLanes-1:0] laneValid;
	categoryT laneCategory [NumLanes];

	// result fifo
	categoryT resultBuf [ResultDepth];
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [CountWidth-1:0] count;
	// free slots at the downstream receiver
	logic [SinkWidth-1:0] sinkCredits;
	// lane that holds the oldest hand in flight
	logic [LaneWidth-1:0] expectLane;
	logic accept;

	for (genvar i = 0; i < NumLanes; i++) begin : laneGather
		assign laneValid[i] = lanes[i].resultValid;
		assign laneCategory[i] = lanes[i].category;
	end

	// hands were issued round robin, so results arrive in the same rotation
	assign accept = laneValid[expectLane];
	assign outValid = (count != '0) && (sinkCredits != '0);
	assign outCategory = resultBuf[rdPtr];

	// no room check needed, the dispatcher reserved the slot
	always_ff @(posedge clk) begin
		if (accept) begin
			resultBuf[wrPtr] <= laneCategory[expectLane];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			sinkCredits <= SinkWidth'(SinkDepth);
			expectLane <= '0;
			resultCredit <= 1'b0;
		end else begin
			// slot freed, hand it back to the dispatcher
			resultCredit <= outValid;
			if (accept) begin
				if (wrPtr == PtrWidth'(ResultDepth - 1)) begin
					wrPtr <= '0;
				end else begin
					wrPtr <= wrPtr + PtrWidth'(1);
				end
				if (expectLane == LaneWidth'(NumLanes - 1)) begin
					expectLane <= '0;
				end else begin
					expectLane <= expectLane + LaneWidth'(1);
				end
			end
			if (outValid) begin
				if (rdPtr == PtrWidth'(ResultDepth - 1)) begin
					rdPtr <= '0;
				end else begin
					rdPtr <= rdPtr + PtrWidth'(1);
				end
			end
			count <= count + CountWidth'(accept) - CountWidth'(outValid);
			sinkCredits <= sinkCredits - SinkWidth'(outValid) + SinkWidth'(outCredit);
		end
	end

	// any other lane finishing means the rotation broke
	laneInTurn: assert property (@(posedge clk) disable iff (reset)
		(laneValid & ~(NumLanes'(1) << expectLane)) == '0);

	// the sink never frees more slots than it has
	sinkCreditBound: assert property (@(posedge clk) disable iff (reset)
		sinkCredits <= SinkWidth'(SinkDepth));

endmodule

`default_nettype wire

// File: pokerHandEvaluator.sv
`default_nettype none

module pokerHandEvaluator #(
	parameter int NumLanes = 3,
	parameter int InDepth = 4,
	parameter int ResultDepth = 4,
	parameter int SinkDepth = 2
) (
	input  logic clk,
	input  logic reset,
	input  logic inValid,
	input  pokerPkg::handT inHand,
	output logic inCredit,
	output logic outValid,
	output pokerPkg::categoryT outCategory,
	input  logic outCredit
);

	// one link per classifier lane
	laneIf lanes [NumLanes] ();
	// result slots handed back from collector to dispatcher
	logic resultCredit;

	handDispatcher #(
		.NumLanes(NumLanes),
		.InDepth(InDepth),
		.ResultDepth(ResultDepth)
	) dispatcher (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inHand(inHand),
		.inCredit(inCredit),
		.resultCredit(resultCredit),
		.lanes(lanes)
	);

	for (genvar i = 0; i < NumLanes; i++) begin : laneGen
		handClassifier classifier (
			.clk(clk),
			.reset(reset),
			.lane(lanes[i])
		);
	end

	resultCollector #(
		.NumLanes(NumLanes),
		.ResultDepth(ResultDepth),
		.SinkDepth(SinkDepth)
	) collector (
		.clk(clk),
		.reset(reset),
		.lanes(lanes),
		.resultCredit(resultCredit),
		.outValid(outValid),
		.outCategory(outCategory),
		.outCredit(outCredit)
	);

endmodule

`default_nettype wire

// File: tbPokerEval.sv
`default_nettype none

module tbPokerEval;
	import pokerPkg::*;

	// mirrors of the DUT buffer sizes
	localparam int InDepth = 4;
	localparam int SinkDepth = 2;
	localparam int ResetCycles = 10;
	localparam int MaxTests = 64;
	// timeout budget per hand, plus a fixed margin
	localparam int CyclesPerTest = 40;
	localparam int TimeoutMargin = 200;
	// idle cycles after the last result to catch stray beats
	localparam int DrainCycles = 30;
	localparam int HandBits = NumCards * CardWidth;
	// no hand sets the top two bits, so this marks unused rows
	localparam logic [31:0] EmptyRow = 32'hFFFF_FFFF;

	logic clk;
	logic reset;
	logic inValid;
	handT inHand;
	logic inCredit;
	logic outValid;
	categoryT outCategory;
	logic outCredit;

	// hand and expected category in alternating words
	logic [31:0] testMem [2*MaxTests];
	int numTests = 0;
	int timeoutLimit = 0;
	int cycleCount = 0;
	int seed = 32426;

	// expected categories in send order
	categoryT expectQueue [$];
	int sentCount = 0;
	int receivedCount = 0;
	int inCreditPulses = 0;
	int outCreditPulses = 0;
	int outBeats = 0;
	// results the sink has released again
	int freedCount = 0;
	int cyclesOutOfReset = 0;
	int checkErrors = 0;
	int endErrors = 0;

	pokerHandEvaluator #(
		.InDepth(InDepth),
		.SinkDepth(SinkDepth)
	) DUT (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inHand(inHand),
		.inCredit(inCredit),
		.outValid(outValid),
		.outCategory(outCategory),
		.outCredit(outCredit)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	// reads the vector file and counts its rows
	task automatic loadTests();
		for (int i = 0; i < 2*MaxTests; i++) begin
			testMem[i] = EmptyRow;
		end
		$readmemh("pokerTests.txt", testMem);
		numTests = 0;
		while (numTests < MaxTests && testMem[2*numTests] != EmptyRow) begin
			numTests++;
		end
	endtask

	task automatic reportMismatch(input string name, input int expectedVal, input int actualVal);
		$display("CHECK FAILED at time %0t: %s expected %0d, got %0d",
			$time, name, expectedVal, actualVal);
		checkErrors++;
	endtask

	// source side, one hand per credit
	initial begin : mainFlow
		reset = 1'b1;
		inValid = 1'b0;
		inHand = '0;
		loadTests();
		timeoutLimit = numTests * CyclesPerTest + TimeoutMargin;
		if (numTests == 0) begin
			$display("no test vectors found in pokerTests.txt");
			endErrors++;
		end
		repeat (ResetCycles) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < numTests; i++) begin
			@(posedge clk);
			// credits held are the initial ones plus returns minus hands sent
			while (InDepth + inCreditPulses - sentCount <= 0) begin
				inValid <= 1'b0;
				@(posedge clk);
			end
			inValid <= 1'b1;
			inHand <= testMem[2*i][HandBits-1:0];
			expectQueue.push_back(testMem[2*i+1][CategoryWidth-1:0]);
			sentCount++;
		end
		@(posedge clk);
		inValid <= 1'b0;
		while (receivedCount < numTests) begin
			@(posedge clk);
		end
		repeat (DrainCycles) @(posedge clk);
		if (expectQueue.size() != 0) begin
			$display("%0d expected results never came back", expectQueue.size());
			endErrors++;
		end
		if (inCreditPulses != sentCount) begin
			$display("inCredit returned %0d credits for %0d hands sent",
				inCreditPulses, sentCount);
			endErrors++;
		end
		$display("tests %0d, sent %0d, received %0d, errors %0d",
			numTests, sentCount, receivedCount, checkErrors + endErrors);
		if (checkErrors + endErrors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// sink frees slots after random delays, with long holds now and then
	initial begin : sinkModel
		int stallLeft;
		int roll;
		stallLeft = 0;
		outCredit = 1'b0;
		forever begin
			@(posedge clk);
			roll = $random(seed);
			outCredit <= 1'b0;
			if (reset) begin
				stallLeft = 0;
			end else if (stallLeft > 0) begin
				stallLeft--;
			end else if ((roll & 31) == 0) begin
				// long hold, results pile up inside the DUT
				stallLeft = 20 + ((roll >> 5) & 31);
			end else if (outBeats > freedCount && ((roll >> 10) & 3) != 0) begin
				outCredit <= 1'b1;
				freedCount++;
			end
		end
	end

	// outputs sampled mid cycle, away from the active edge
	initial begin : outputMonitor
		categoryT expected;
		// registers take their reset values on the first edge
		@(posedge clk);
		forever begin
			@(negedge clk);
			// quiet through reset and the first cycles after it
			if (reset || cyclesOutOfReset < 2) begin
				if (outValid !== 1'b0) begin
					reportMismatch("outValid", 0, outValid);
				end
				if (inCredit !== 1'b0) begin
					reportMismatch("inCredit", 0, inCredit);
				end
			end
			if (!reset) begin
				cyclesOutOfReset++;
				if (inCredit) begin
					inCreditPulses++;
				end
				if (outValid) begin
					// only credits granted before this cycle count
					if (outBeats >= SinkDepth + outCreditPulses) begin
						$display("outValid at time %0t without a free sink slot", $time);
						checkErrors++;
					end
					outBeats++;
					if (expectQueue.size() == 0) begin
						$display("outValid at time %0t with no result outstanding", $time);
						checkErrors++;
					end else begin
						expected = expectQueue.pop_front();
						if (outCategory !== expected) begin
							reportMismatch("outCategory", expected, outCategory);
						end
						receivedCount++;
					end
				end
				if (outCredit) begin
					outCreditPulses++;
				end
			end
		end
	end

	// ends a hung run
	initial begin : watchdog
		while (timeoutLimit == 0 || cycleCount <= timeoutLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout after %0d cycles, %0d of %0d results back",
			cycleCount, receivedCount, numTests);
		$display("tests %0d, sent %0d, received %0d, errors %0d",
			numTests, sentCount, receivedCount, checkErrors + endErrors);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: pokerTests.txt
// columns: hand as 8 hex digits (card 4 in the top bits, card 0 lowest), expected category
// a card is {suit, rank}; the comment lists card 0 first, suits c d h s = 0 1 2 3
21B6CAEA 8 // Th Jh Qh Kh Ah
05103081 8 // Ac 2c 3c 4c 5c
39E37DB5 8 // 5s 6s 7s 8s 9s
154D4496 8 // 6d 2d 4d 3d 5d
39EBBF3D 8 // Ks Qs Js Ts 9s
0DDE75C7 7 // 7c 7d 7h 7s Kc
21441C62 7 // 2h As Ac Ad Ah
2DF6574D 7 // Kc Kd 5h Ks Kh
04D2D74D 6 // Kc Kd Kh 4s 4c
39CE94C9 6 // 9c 3d 9h 3s 9s
11F61741 6 // Ac Kd Ah Ks Ad
2DAE8962 5 // 2h 5h 8h Jh Kh
38DB5D33 5 // 3s 4s 5s 6s 8s
092CC341 5 // Ac Kc Qc Jc 9c
238A1B6C 5 // Qh Kh Ah 2h 3h
01F6C6CA 4 // Tc Jd Qh Ks Ac
0BF2A351 4 // Ad Kc Th Qs Jc
359130B1 4 // As 2c 3d 4h 5s
01CA3505 4 // 5c 4d 3h 2s Ac
08DEA589 4 // 9c 6d Th 7s 8c
2DF0B6A9 4 // 9h Td Jc Qs Kh
02F68608 3 // 8c 8d 8h Ks 2c
0CA5C0FC 3 // Qs 3c Qd 9h Qc
09C61541 3 // Ac 5d Ah As 9c
01D246CB 2 // Jc Jd 4h 4s Ac
0ADA9686 2 // 6c Td 9h 6s Tc
03E28441 2 // Ac Ad 8h 8s 3c
0DE674C3 1 // 3c 3d 7h 9s Kc
11078952 1 // 2d 5h 8s Ac Ad
04F6709D 1 // Kd 2c 7h Ks 4c
08E27585 1 // 5c 6d 7h 8s 8c
06DA44C2 1 // 2c 3d 4h 6s 6c
0BEEC741 1 // Ac Kd Qh Js Jc
351538B1 1 // As 2h 3d 5c 5s
0DEE9542 0 // 2c 5d 9h Js Kc
09EEC741 0 // Ac Kd Qh Js 9c
120F4957 0 // 7d 5h 4s 3c 2d
1C2989B3 0 // 3s 6h 8d Tc Qd
03CA174C 0 // Qc Kd Ah 2s 3c
1207DB1B 0 // Jd Qh Ks Ac 2d

// File: pokerEval.f
pokerPkg.sv
laneIf.sv
handDispatcher.sv
rankGroupCounter.sv
handClassifier.sv
resultCollector.sv
pokerHandEvaluator.sv
tbPokerEval.sv

// File: runSim.sh
#!/usr/bin/env bash
# build the poker evaluator testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -j 0 --top-module tbPokerEval \
	-f pokerEval.f --Mdir obj_dir -o simPoker; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/simPoker)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "RESULT: PASS" <<< "$output"; then
	exit 0
fi
exit 1
